// ==== design/net_cfg.svh ====
`ifndef NET_CFG_SVH
`define NET_CFG_SVH

// Number of distinct points that can appear in a pair
`define NET_NUM_POINTS 64

// Largest number of pairs in one stream, which also bounds the network ids
`define NET_NUM_CONNS 64

// Number of largest network sizes reported at the end
`define NET_NUM_TOP 3

`endif

// ==== design/net_cmd_pkg.sv ====
`include "net_cfg.svh"

package net_cmd_pkg;

    localparam int POINT_W  = $clog2(`NET_NUM_POINTS);

    // Id 0 means no network, so one extra code is needed
    localparam int NET_ID_W = $clog2(`NET_NUM_CONNS + 1);

    typedef logic [POINT_W-1:0]  point_id_t;
    typedef logic [NET_ID_W-1:0] net_id_t;

    // Handling of one pair as it moves through decode and execute
    typedef enum logic [2:0] {
        IGNORE,
        NEW,
        LOOKUP,
        WR_A,
        WR_B,
        MERGE
    } net_action_t;

endpackage

// ==== design/net_size_pkg.sv ====
`include "net_cfg.svh"

package net_size_pkg;

    // Room for a network that spans every connection plus headroom for the sum
    localparam int NET_SIZE_W = $clog2(`NET_NUM_CONNS) + 2;

    typedef logic [NET_SIZE_W-1:0] net_size_t;

    // Entry 0 holds the largest size
    typedef net_size_t [`NET_NUM_TOP-1:0] net_rank_t;

endpackage

// ==== design/net_ifs.sv ====
`timescale 1ns/1ps

// Decoded pair handed from decode to execute
interface net_lookup_if import net_cmd_pkg::*; ();
    net_action_t action;
    point_id_t   point_a;
    point_id_t   point_b;
    net_id_t     net_a;
    net_id_t     net_b;
    logic        busy;

    modport src (output action, point_a, point_b, net_a, net_b, input busy);
    modport snk (input action, point_a, point_b, net_a, net_b, output busy);
endinterface

// Point table writes from execute, merged with the decode writes in decode
interface point_wr_if import net_cmd_pkg::*; ();
    logic      wen_a;
    logic      wen_b;
    point_id_t addr_a;
    point_id_t addr_b;
    net_id_t   data_a;
    net_id_t   data_b;

    modport src (output wen_a, wen_b, addr_a, addr_b, data_a, data_b);
    modport rcv (input wen_a, wen_b, addr_a, addr_b, data_a, data_b);
endinterface

// One pulse per size change, from execute to the result stage
interface size_upd_if import net_cmd_pkg::*; ();
    net_action_t action;
    net_id_t     net_a;
    net_id_t     net_b;
    net_id_t     new_id;

    modport src (output action, net_a, net_b, new_id);
    modport snk (input action, net_a, net_b, new_id);
endinterface

// ==== design/net_ram.sv ====
`timescale 1ns/1ps

module net_ram #(
    parameter int DEPTH = 64,
    parameter int WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [1:0][$clog2(DEPTH)-1:0] raddr,
    input  logic [1:0]                    ren,
    output logic [1:0][WIDTH-1:0]         rdata,
    input  logic [1:0][$clog2(DEPTH)-1:0] waddr,
    input  logic [1:0]                    wen,
    input  logic [1:0][WIDTH-1:0]         wdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // A read in the same cycle as a write to that entry returns the old contents
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (ren[p]) begin
                rdata[p] <= mem[raddr[p]];
            end
        end
    end

    // Every entry starts at zero since zero marks an unused id or size
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // Port b is applied last so it wins on a shared address
            for (int p = 0; p < 2; p++) begin
                if (wen[p]) begin
                    mem[waddr[p]] <= wdata[p];
                end
            end
        end
    end

endmodule

// ==== design/point_decode.sv ====
`timescale 1ns/1ps
`include "net_cfg.svh"

module point_decode import net_cmd_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  point_id_t pointa_in,
    input  point_id_t pointb_in,
    input  logic      points_in_vld,
    output logic      points_in_rdy,
    output logic      points_done,
    net_lookup_if.src lk,
    point_wr_if.rcv   pw,
    input  net_id_t   new_id,
    input  logic      result_busy
);

    logic            accept;
    logic            acc_r;
    logic            started;
    logic            own_new;
    point_id_t       pt_a_r;
    point_id_t       pt_b_r;
    net_id_t   [1:0] pt_rdata;
    logic      [1:0] pt_wen;
    point_id_t [1:0] pt_waddr;
    net_id_t   [1:0] pt_wdata;

    assign accept = points_in_vld && points_in_rdy;

    // Only one pair is in flight, ready returns when execute has let go of it
    assign points_in_rdy = !acc_r && !lk.busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_r       <= 1'b0;
            started     <= 1'b0;
            points_done <= 1'b0;
        end else begin
            acc_r   <= accept;
            started <= started || accept;
            // Stream is over once input goes quiet and no stage has work left
            if (started && !points_in_vld && !acc_r && !lk.busy && !result_busy) begin
                points_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pt_a_r <= pointa_in;
            pt_b_r <= pointb_in;
        end
    end

    // Network ids of both points arrive one cycle after acceptance
    always_comb begin
        lk.action = IGNORE;
        if (acc_r) begin
            if (pt_rdata[0] != pt_rdata[1]) begin
                lk.action = LOOKUP;
            end else if (pt_rdata[0] == '0 && pt_a_r != pt_b_r) begin
                lk.action = NEW;
            end
        end
    end

    assign lk.point_a = pt_a_r;
    assign lk.point_b = pt_b_r;
    assign lk.net_a   = pt_rdata[0];
    assign lk.net_b   = pt_rdata[1];

    // Decode writes only on NEW, every other write comes from execute
    assign own_new  = (lk.action == NEW);
    assign pt_wen   = own_new ? 2'b11 : {pw.wen_b, pw.wen_a};
    assign pt_waddr = own_new ? {pt_b_r, pt_a_r} : {pw.addr_b, pw.addr_a};
    assign pt_wdata = own_new ? {new_id, new_id} : {pw.data_b, pw.data_a};

    net_ram #(
        .DEPTH (`NET_NUM_POINTS),
        .WIDTH ($bits(net_id_t))
    ) u_point_table (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr ({pointb_in, pointa_in}),
        .ren   ({2{accept}}),
        .rdata (pt_rdata),
        .waddr (pt_waddr),
        .wen   (pt_wen),
        .wdata (pt_wdata)
    );

endmodule

// ==== design/net_remap_execute.sv ====
`timescale 1ns/1ps
`include "net_cfg.svh"

module net_remap_execute import net_cmd_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    net_lookup_if.snk lk,
    point_wr_if.src   pw,
    size_upd_if.src   su,
    output net_id_t   new_id
);

    logic          start;
    logic          active;
    logic          chain_done;
    logic    [1:0] rd_pend;
    logic    [1:0] live;
    net_id_t       cur_a;
    net_id_t       cur_b;
    point_id_t     pt_a;
    point_id_t     pt_b;
    net_action_t   decision;
    net_action_t   act;
    net_id_t [1:0] rm_raddr;
    net_id_t [1:0] rm_rdata;
    logic    [1:0] rm_ren;
    logic    [1:0] rm_wen;

    assign start = (lk.action == LOOKUP);

    // A side keeps walking while the entry it just read links to a newer id
    assign live[0]    = rd_pend[0] && (rm_rdata[0] != '0);
    assign live[1]    = rd_pend[1] && (rm_rdata[1] != '0);
    assign chain_done = active && (live == 2'b00);
    assign lk.busy    = active;

    assign rm_raddr[0] = start ? lk.net_a : rm_rdata[0];
    assign rm_raddr[1] = start ? lk.net_b : rm_rdata[1];
    assign rm_ren[0]   = start ? (lk.net_a != '0) : live[0];
    assign rm_ren[1]   = start ? (lk.net_b != '0) : live[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active  <= 1'b0;
            rd_pend <= 2'b00;
            new_id  <= net_id_t'(1);
        end else begin
            rd_pend <= rm_ren;
            if (start) begin
                active <= 1'b1;
            end else if (chain_done) begin
                active <= 1'b0;
            end
            if (act == NEW || act == MERGE) begin
                new_id <= new_id + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur_a <= lk.net_a;
            cur_b <= lk.net_b;
            pt_a  <= lk.point_a;
            pt_b  <= lk.point_b;
        end else begin
            if (live[0]) begin
                cur_a <= rm_rdata[0];
            end
            if (live[1]) begin
                cur_b <= rm_rdata[1];
            end
        end
    end

    // Final ids decide between joining a lone point and merging two networks
    always_comb begin
        decision = IGNORE;
        if ((cur_a == '0) != (cur_b == '0)) begin
            decision = (cur_a == '0) ? WR_A : WR_B;
        end else if (cur_a != cur_b) begin
            decision = MERGE;
        end
    end

    assign act = chain_done ? decision : ((lk.action == NEW) ? NEW : IGNORE);

    // A lone point takes the other side's network, a merge moves both to the fresh id
    assign pw.wen_a  = (act == WR_A) || (act == MERGE);
    assign pw.wen_b  = (act == WR_B) || (act == MERGE);
    assign pw.addr_a = pt_a;
    assign pw.addr_b = pt_b;
    assign pw.data_a = (act == WR_A) ? cur_b : new_id;
    assign pw.data_b = (act == WR_B) ? cur_a : new_id;

    // Both retired ids link forward to the merged network
    assign rm_wen = {2{act == MERGE}};

    assign su.action = act;
    assign su.net_a  = cur_a;
    assign su.net_b  = cur_b;
    assign su.new_id = new_id;

    net_ram #(
        .DEPTH (`NET_NUM_CONNS + 1),
        .WIDTH ($bits(net_id_t))
    ) u_remap_table (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (rm_raddr),
        .ren   (rm_ren),
        .rdata (rm_rdata),
        .waddr ({cur_b, cur_a}),
        .wen   (rm_wen),
        .wdata ({new_id, new_id})
    );

endmodule

// ==== design/net_size_result.sv ====
`timescale 1ns/1ps
`include "net_cfg.svh"

module net_size_result import net_cmd_pkg::*, net_size_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    size_upd_if.snk   su,
    input  logic      points_done,
    output logic      busy,
    output net_rank_t net_sizes,
    output logic      net_sizes_final
);

    net_action_t             s1_action;
    net_id_t                 s1_net_a;
    net_id_t                 s1_net_b;
    net_id_t                 s1_new_id;
    logic                    s2_clr;
    net_id_t                 s2_addr;
    net_id_t                 sweep_addr;
    logic                    sweep_rd;
    logic                    sweep_vld;
    net_id_t   [1:0]         sz_raddr;
    net_id_t   [1:0]         sz_waddr;
    logic      [1:0]         sz_ren;
    logic      [1:0]         sz_wen;
    net_size_t [1:0]         sz_rdata;
    net_size_t [1:0]         sz_wdata;
    net_rank_t               rank;
    net_rank_t               rank_up;
    logic [`NET_NUM_TOP-1:0] gt;
    logic [`NET_NUM_TOP-1:0] gt_prev;

    // Port a reads side a, port b reads side b or the sweep entry
    assign sz_ren[0]   = (su.action == WR_B) || (su.action == MERGE);
    assign sz_raddr[0] = su.net_a;
    assign sz_ren[1]   = sweep_rd || (su.action == WR_A) || (su.action == MERGE);
    assign sz_raddr[1] = sweep_rd ? sweep_addr : su.net_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_action <= IGNORE;
            s2_clr    <= 1'b0;
        end else begin
            s1_action <= su.action;
            s2_clr    <= (s1_action == MERGE);
        end
    end

    always_ff @(posedge clk) begin
        s1_net_a  <= su.net_a;
        s1_net_b  <= su.net_b;
        s1_new_id <= su.new_id;
        s2_addr   <= s1_net_b;
    end

    // Port a writes the new or grown size once the old sizes are back
    always_comb begin
        sz_wen[0]   = 1'b1;
        sz_waddr[0] = s1_new_id;
        sz_wdata[0] = net_size_t'(2);
        case (s1_action)
            NEW:   sz_wdata[0] = net_size_t'(2);
            WR_A: begin
                sz_waddr[0] = s1_net_b;
                sz_wdata[0] = sz_rdata[1] + 1'b1;
            end
            WR_B: begin
                sz_waddr[0] = s1_net_a;
                sz_wdata[0] = sz_rdata[0] + 1'b1;
            end
            MERGE: sz_wdata[0] = sz_rdata[0] + sz_rdata[1];
            default: sz_wen[0] = 1'b0;
        endcase
    end

    // Port b clears the two merged-away entries over two cycles
    assign sz_wen[1]   = (s1_action == MERGE) || s2_clr;
    assign sz_waddr[1] = s2_clr ? s2_addr : s1_net_a;
    assign sz_wdata[1] = '0;

    assign busy = (s1_action != IGNORE) || s2_clr;

    assign sweep_rd = points_done && (sweep_addr != net_id_t'(`NET_NUM_CONNS + 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweep_addr      <= '0;
            sweep_vld       <= 1'b0;
            net_sizes_final <= 1'b0;
        end else begin
            if (sweep_rd) begin
                sweep_addr <= sweep_addr + 1'b1;
            end
            sweep_vld <= sweep_rd;
            if (sweep_vld && !sweep_rd) begin
                net_sizes_final <= 1'b1;
            end
        end
    end

    // Ranking stays descending so gt is set from the insert point downward
    always_comb begin
        rank_up = '0;
        gt_prev = '0;
        for (int i = 0; i < `NET_NUM_TOP; i++) begin
            gt[i] = sz_rdata[1] > rank[i];
        end
        for (int i = 1; i < `NET_NUM_TOP; i++) begin
            gt_prev[i] = gt[i-1];
            rank_up[i] = rank[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rank <= '0;
        end else if (sweep_vld && sz_rdata[1] != '0) begin
            for (int i = 0; i < `NET_NUM_TOP; i++) begin
                if (gt[i]) begin
                    rank[i] <= gt_prev[i] ? rank_up[i] : sz_rdata[1];
                end
            end
        end
    end

    assign net_sizes = rank;

    net_ram #(
        .DEPTH (`NET_NUM_CONNS + 1),
        .WIDTH ($bits(net_size_t))
    ) u_size_table (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (sz_raddr),
        .ren   (sz_ren),
        .rdata (sz_rdata),
        .waddr (sz_waddr),
        .wen   (sz_wen),
        .wdata (sz_wdata)
    );

endmodule

// ==== design/point_ntwrk.sv ====
`timescale 1ns/1ps
`include "net_cfg.svh"

module point_ntwrk import net_cmd_pkg::*, net_size_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [$clog2(`NET_NUM_POINTS)-1:0] pointa_in,
    input  logic [$clog2(`NET_NUM_POINTS)-1:0] pointb_in,
    input  logic                               points_in_vld,
    output logic                               points_in_rdy,
    output net_rank_t                          net_sizes,
    output logic                               net_sizes_final
);

    net_id_t new_id;
    logic    points_done;
    logic    result_busy;

    net_lookup_if lk_if ();
    point_wr_if   pw_if ();
    size_upd_if   su_if ();

    point_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .pointa_in     (pointa_in),
        .pointb_in     (pointb_in),
        .points_in_vld (points_in_vld),
        .points_in_rdy (points_in_rdy),
        .points_done   (points_done),
        .lk            (lk_if.src),
        .pw            (pw_if.rcv),
        .new_id        (new_id),
        .result_busy   (result_busy)
    );

    net_remap_execute u_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .lk     (lk_if.snk),
        .pw     (pw_if.src),
        .su     (su_if.src),
        .new_id (new_id)
    );

    net_size_result u_result (
        .clk             (clk),
        .rst_n           (rst_n),
        .su              (su_if.snk),
        .points_done     (points_done),
        .busy            (result_busy),
        .net_sizes       (net_sizes),
        .net_sizes_final (net_sizes_final)
    );

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// ==== verification/point_ntwrk_tb.sv ====
`timescale 1ns/1ps
`include "net_cfg.svh"

module point_ntwrk_tb import net_cmd_pkg::*, net_size_pkg::*; ();

    localparam int NUM_DIRECTED = 5;
    localparam int DIR_PAIRS    = 33;
    localparam int RAND_PAIRS   = 40;
    localparam int NUM_CASES    = NUM_DIRECTED + 1;

    // Pairs of all directed cases back to back in case order
    int dir_pairs [DIR_PAIRS][2] = '{
        '{0, 1}, '{2, 3}, '{4, 5},
        '{10, 11}, '{11, 12}, '{13, 12},
        '{0, 1}, '{2, 3}, '{1, 2}, '{4, 5}, '{3, 5}, '{6, 7}, '{0, 7}, '{20, 21},
        '{30, 31}, '{31, 32}, '{31, 30}, '{32, 30}, '{30, 31}, '{33, 33}, '{32, 31},
        '{40, 41}, '{42, 43}, '{41, 42}, '{43, 40},
        '{5, 6}, '{7, 5}, '{5, 8}, '{9, 10}, '{10, 8}, '{50, 51}, '{52, 53}, '{53, 54}
    };
    int dir_len [NUM_DIRECTED] = '{3, 3, 8, 11, 8};

    // Expected ranking of each directed case with the largest network first
    int dir_exp [NUM_DIRECTED][`NET_NUM_TOP] = '{
        '{2, 2, 2}, '{4, 0, 0}, '{8, 2, 0}, '{4, 3, 0}, '{6, 3, 2}
    };

    logic      clk;
    logic      rst_n;
    point_id_t pointa_in;
    point_id_t pointb_in;
    logic      points_in_vld;
    logic      points_in_rdy;
    net_rank_t net_sizes;
    logic      net_sizes_final;

    point_id_t pair_a [$];
    point_id_t pair_b [$];
    int        exp_rank [`NET_NUM_TOP];
    int        seed;
    int        cycles = 0;
    int        cycle_limit;

    tb_clk_gen #(.PERIOD(20.0)) clk_gen_i (.clk(clk));

    point_ntwrk point_ntwrk_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .pointa_in       (pointa_in),
        .pointb_in       (pointb_in),
        .points_in_vld   (points_in_vld),
        .points_in_rdy   (points_in_rdy),
        .net_sizes       (net_sizes),
        .net_sizes_final (net_sizes_final)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic int case_length(input int c);
        if (c < NUM_DIRECTED) begin
            return dir_len[c];
        end
        return RAND_PAIRS;
    endfunction

    task automatic load_case(input int c);
        int first;
        first = 0;
        pair_a.delete();
        pair_b.delete();
        if (c < NUM_DIRECTED) begin
            for (int k = 0; k < c; k++) begin
                first += dir_len[k];
            end
            for (int k = first; k < first + dir_len[c]; k++) begin
                pair_a.push_back(point_id_t'(dir_pairs[k][0]));
                pair_b.push_back(point_id_t'(dir_pairs[k][1]));
            end
        end else begin
            // Half the point range, so random pairs meet and merge often
            for (int k = 0; k < RAND_PAIRS; k++) begin
                pair_a.push_back(point_id_t'({$random(seed)} % (`NET_NUM_POINTS / 2)));
                pair_b.push_back(point_id_t'({$random(seed)} % (`NET_NUM_POINTS / 2)));
            end
        end
    endtask

    // Union-find over the current pairs, then the largest components in descending order
    task automatic compute_expected_rank();
        int parent [`NET_NUM_POINTS];
        int comp_size [`NET_NUM_POINTS];
        int ra;
        int rb;
        int slot;
        for (int p = 0; p < `NET_NUM_POINTS; p++) begin
            parent[p]    = p;
            comp_size[p] = 1;
        end
        for (int k = 0; k < pair_a.size(); k++) begin
            ra = pair_a[k];
            rb = pair_b[k];
            while (parent[ra] != ra) ra = parent[ra];
            while (parent[rb] != rb) rb = parent[rb];
            if (ra != rb) begin
                parent[ra]     = rb;
                comp_size[rb] += comp_size[ra];
            end
        end
        for (int i = 0; i < `NET_NUM_TOP; i++) begin
            exp_rank[i] = 0;
        end
        // A lone point is no network and is never ranked
        for (int p = 0; p < `NET_NUM_POINTS; p++) begin
            if (parent[p] == p && comp_size[p] > 1) begin
                slot = `NET_NUM_TOP;
                for (int i = `NET_NUM_TOP - 1; i >= 0; i--) begin
                    if (comp_size[p] > exp_rank[i]) begin
                        slot = i;
                    end
                end
                for (int i = `NET_NUM_TOP - 1; i > slot; i--) begin
                    exp_rank[i] = exp_rank[i-1];
                end
                if (slot < `NET_NUM_TOP) begin
                    exp_rank[slot] = comp_size[p];
                end
            end
        end
    endtask

    task automatic run_case(input int c);
        $display("Case %0d with %0d pairs", c, pair_a.size());
        rst_n         = 1'b0;
        points_in_vld = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_value("points_in_rdy", points_in_rdy, 1);
        check_value("net_sizes_final", net_sizes_final, 0);
        check_value("net_sizes", net_sizes, 0);
        // Valid stays high from pair to pair, a gap would end the stream early
        for (int i = 0; i < pair_a.size(); i++) begin
            pointa_in     = pair_a[i];
            pointb_in     = pair_b[i];
            points_in_vld = 1'b1;
            while (!points_in_rdy) @(negedge clk);
            check_value("net_sizes_final", net_sizes_final, 0);
            @(negedge clk);
        end
        points_in_vld = 1'b0;
        while (!net_sizes_final) @(negedge clk);
        compute_expected_rank();
        for (int i = 0; i < `NET_NUM_TOP; i++) begin
            check_value($sformatf("net_sizes[%0d]", i), net_sizes[i], exp_rank[i]);
            if (c < NUM_DIRECTED) begin
                check_value($sformatf("net_sizes[%0d]", i), net_sizes[i], dir_exp[c][i]);
            end
        end
        repeat (3) @(negedge clk);
        check_value("net_sizes_final", net_sizes_final, 1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the test cases did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    initial begin
        rst_n         = 1'b0;
        pointa_in     = '0;
        pointb_in     = '0;
        points_in_vld = 1'b0;
        seed          = 48;
        cycle_limit   = 0;
        for (int c = 0; c < NUM_CASES; c++) begin
            cycle_limit += 20 * case_length(c) + `NET_NUM_CONNS + 30;
        end
        for (int c = 0; c < NUM_CASES; c++) begin
            load_case(c);
            run_case(c);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== point_ntwrk.f ====
+incdir+design
design/net_cmd_pkg.sv
design/net_size_pkg.sv
design/net_ifs.sv
design/net_ram.sv
design/point_decode.sv
design/net_remap_execute.sv
design/net_size_result.sv
design/point_ntwrk.sv
verification/tb_clk_gen.sv
verification/point_ntwrk_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing -Wno-fatal
TOP       = point_ntwrk_tb
RTL_TOP   = point_ntwrk
FILELIST  = point_ntwrk.f
LOG       = sim.log
PASS_MSG  = NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
